/* seg_display_top.f */
hdl/seg_pkg.sv
hdl/hex_digit_decoder.sv
hdl/switch_debouncer.sv
hdl/seg_register_bank.sv
hdl/seg_display_top.sv
tests/seg_display_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = seg_display_tb
FILELIST = seg_display_top.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/seg_display_tb.sv */
`timescale 1ns/10ps

module seg_display_tb;

  import seg_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int DRIVE_DELAY     = 2;
  localparam int RESET_CYCLES    = 3;
  localparam int BUS_TIMEOUT     = 4;
  localparam int SETTLE_CYCLES   = 2 + DEBOUNCE_CYCLES + 3;
  localparam int GLITCH_CYCLES   = DEBOUNCE_CYCLES / 2;
  localparam int WATCHDOG_CYCLES = 40;
  localparam logic [31:0] SW_ADDR = 32'h0000_0020;

  // Glyphs in g f e d c b a order, one per code.
  localparam logic [6:0] GLYPH [32] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71,
    7'h00, 7'h40, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,
    7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00
  };

  typedef enum logic [2:0] {
    OP_WR_DIGIT,
    OP_RD_DIGIT,
    OP_SET_SW,
    OP_GLITCH_SW,
    OP_WR_SW_ADDR
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] idx;
    logic [31:0] data;
    logic [31:0] expected;
  } entry_t;

  logic                clk_i;
  logic                rst_i;
  wb_req_t             wb_req;
  wb_rsp_t             wb_rsp;
  logic [SW_WIDTH-1:0] sw;
  seg_digits_t         seg;

  entry_t     stim_table[$];
  logic       table_ready;
  logic [6:0] exp_seg [NUM_DIGITS];
  int         err_count;
  int         check_count;
  int         ack_count;
  int         seed;

  seg_display_top dut_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp),
    .sw_i     (sw),
    .seg_o    (seg)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Ack is one cycle wide, so one sample per cycle counts it.
  always @(negedge clk_i)
  begin
    if (!rst_i && wb_rsp.ack)
      ack_count++;
  end

  initial
  begin
    wait (table_ready);
    #(stim_table.size() * WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected)
    else
    begin
      $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
  endtask

  task automatic check_segments();
    for (int i = 0; i < NUM_DIGITS; i++)
      check_value($sformatf("seg_o[%0d]", i), 32'(exp_seg[i]), 32'(seg[i]));
  endtask

  task automatic bus_access(input logic we, input logic [31:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    int   acks_before;
    int   waited;
    logic got_ack;
    acks_before = ack_count;
    got_ack     = 1'b0;
    waited      = 0;
    rdat        = '0;
    wb_req.cyc  = 1'b1;
    wb_req.stb  = 1'b1;
    wb_req.we   = we;
    wb_req.adr  = adr;
    wb_req.dat  = wdat;
    while (!got_ack && waited < BUS_TIMEOUT)
    begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      waited++;
      check_value("wb_rsp_o.stall", 32'd0, 32'(wb_rsp.stall));
      if (wb_rsp.ack)
      begin
        got_ack = 1'b1;
        rdat    = wb_rsp.dat;
      end
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    if (!got_ack)
    begin
      $display("Bus timeout: address %h was not acknowledged within %0d cycles",
               adr, BUS_TIMEOUT);
      err_count++;
    end
    wait_cycles(1);
    check_value("ack count", 32'd1, 32'(ack_count - acks_before));
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
    logic [31:0] discard;
    bus_access(1'b1, adr, dat, discard);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
    bus_access(1'b0, adr, '0, dat);
  endtask

  task automatic add_entry(input op_e op, input logic [31:0] idx,
                           input logic [31:0] data, input logic [31:0] expected);
    entry_t e;
    e.op       = op;
    e.idx      = idx;
    e.data     = data;
    e.expected = expected;
    stim_table.push_back(e);
  endtask

  task automatic build_table();
    int         rnd;
    logic [4:0] code;
    logic [4:0] rand_code [NUM_DIGITS];
    // Only the low five bits are stored.
    add_entry(OP_WR_DIGIT, 0, 32'hffff_ffe3, 32'(GLYPH[3]));
    add_entry(OP_RD_DIGIT, 0, 0, 32'h0000_0003);
    for (int d = 0; d < NUM_DIGITS; d++)
    begin
      for (int c = 0; c < 32; c++)
        add_entry(OP_WR_DIGIT, d, c, 32'(GLYPH[c]));
      add_entry(OP_RD_DIGIT, d, 0, 32'h1f);
      rnd  = $random(seed);
      code = rnd[4:0];
      rand_code[d] = code;
      add_entry(OP_WR_DIGIT, d, 32'(code), 32'(GLYPH[code]));
      add_entry(OP_RD_DIGIT, d, 0, 32'(code));
    end
    for (int d = 0; d < NUM_DIGITS; d++)
      add_entry(OP_RD_DIGIT, d, 0, 32'(rand_code[d]));
    add_entry(OP_SET_SW, 0, 32'h2a5, 32'h2a5);
    add_entry(OP_GLITCH_SW, 0, 32'h15a, 32'h2a5);
    add_entry(OP_WR_SW_ADDR, 0, 32'h3ff, 32'h2a5);
    add_entry(OP_SET_SW, 0, 32'h3ff, 32'h3ff);
    add_entry(OP_GLITCH_SW, 0, 32'h000, 32'h3ff);
    add_entry(OP_SET_SW, 0, 32'h000, 32'h000);
    add_entry(OP_GLITCH_SW, 0, 32'h3ff, 32'h000);
    rnd = $random(seed);
    add_entry(OP_SET_SW, 0, 32'(rnd[9:0]), 32'(rnd[9:0]));
    add_entry(OP_WR_SW_ADDR, 0, 32'h0, 32'(rnd[9:0]));
  endtask

  task automatic apply_entry(input entry_t e);
    logic [31:0]         rdat;
    logic [SW_WIDTH-1:0] prev_sw;
    case (e.op)
      OP_WR_DIGIT:
      begin
        wb_write(e.idx << DIGIT_IDX_LSB, e.data);
        exp_seg[e.idx] = e.expected[6:0];
        check_segments();
      end
      OP_RD_DIGIT:
      begin
        wb_read(e.idx << DIGIT_IDX_LSB, rdat);
        check_value("wb_rsp_o.dat", e.expected, rdat);
      end
      OP_SET_SW:
      begin
        sw = e.data[SW_WIDTH-1:0];
        wait_cycles(SETTLE_CYCLES);
        wb_read(SW_ADDR, rdat);
        check_value("wb_rsp_o.dat", e.expected, rdat);
      end
      OP_GLITCH_SW:
      begin
        prev_sw = sw;
        sw      = e.data[SW_WIDTH-1:0];
        wait_cycles(GLITCH_CYCLES);
        sw = prev_sw;
        wait_cycles(SETTLE_CYCLES);
        wb_read(SW_ADDR, rdat);
        check_value("wb_rsp_o.dat", e.expected, rdat);
      end
      default:
      begin
        wb_write(SW_ADDR, e.data);
        check_segments();
        wb_read(SW_ADDR, rdat);
        check_value("wb_rsp_o.dat", e.expected, rdat);
      end
    endcase
  endtask

  initial
  begin
    int errs_before;
    rst_i       = 1'b1;
    wb_req      = '0;
    sw          = '0;
    err_count   = 0;
    check_count = 0;
    ack_count   = 0;
    seed        = 91;
    table_ready = 1'b0;
    for (int i = 0; i < NUM_DIGITS; i++)
      exp_seg[i] = GLYPH[0];
    build_table();
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b0;

    // Reset state, then an idle bus.
    errs_before = err_count;
    check_segments();
    wait_cycles(5);
    check_value("ack count", 32'd0, 32'(ack_count));
    $display("test reset: %s", (err_count == errs_before) ? "passed" : "failed");

    for (int n = 0; n < stim_table.size(); n++)
    begin
      errs_before = err_count;
      apply_entry(stim_table[n]);
      $display("test %0d %s: %s", n, stim_table[n].op.name(),
               (err_count == errs_before) ? "passed" : "failed");
    end

    $display("%0d tests, %0d checks, %0d errors", stim_table.size() + 1, check_count,
             err_count);
    if (err_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* hdl/seg_display_top.sv */
`timescale 1ns/10ps

module seg_display_top (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  seg_pkg::wb_req_t             wb_req_i,
  output seg_pkg::wb_rsp_t             wb_rsp_o,
  input  logic [seg_pkg::SW_WIDTH-1:0] sw_i,
  output seg_pkg::seg_digits_t         seg_o
);

  import seg_pkg::*;

  // Filtered switch word.
  logic [SW_WIDTH-1:0] sw_db;

  switch_debouncer u_debouncer (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .sw_i  (sw_i),
    .sw_o  (sw_db)
  );

  seg_register_bank u_regs (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .sw_i     (sw_db),
    .seg_o    (seg_o)
  );

endmodule

/* hdl/seg_register_bank.sv */
`timescale 1ns/10ps

module seg_register_bank (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  seg_pkg::wb_req_t             wb_req_i,
  output seg_pkg::wb_rsp_t             wb_rsp_o,
  input  logic [seg_pkg::SW_WIDTH-1:0] sw_i,
  output seg_pkg::seg_digits_t         seg_o
);

  import seg_pkg::*;

  logic                       state_q;
  logic                       state_d;
  logic [DAT_WIDTH-1:0]       result_q;
  logic [DAT_WIDTH-1:0]       result_d;
  digit_code_t [NUM_DIGITS-1:0] codes_q;
  digit_code_t [NUM_DIGITS-1:0] codes_d;

  logic                       accept;
  logic                       sel_sw;
  logic [DIGIT_IDX_WIDTH-1:0] idx;

  // Idle slave takes any strobed cycle.
  assign accept = !state_q && wb_req_i.cyc && wb_req_i.stb;
  assign sel_sw = wb_req_i.adr[SW_REG_BIT];
  assign idx    = wb_req_i.adr[DIGIT_IDX_LSB +: DIGIT_IDX_WIDTH];

  always_comb
  begin
    state_d  = 1'b0;
    result_d = result_q;
    codes_d  = codes_q;
    if (accept)
    begin
      state_d = 1'b1;
      if (!sel_sw)
      begin
        if (wb_req_i.we)
          codes_d[idx] = wb_req_i.dat[CODE_WIDTH-1:0];
        else
          result_d = {{(DAT_WIDTH-CODE_WIDTH){1'b0}}, codes_q[idx]};
      end
      else if (!wb_req_i.we)
        result_d = {{(DAT_WIDTH-SW_WIDTH){1'b0}}, sw_i};
      // Writes to the switch register are dropped.
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q  <= 1'b0;
      result_q <= '0;
      codes_q  <= '0;
    end
    else
    begin
      state_q  <= state_d;
      result_q <= result_d;
      codes_q  <= codes_d;
    end
  end

  assign wb_rsp_o.ack   = state_q;
  assign wb_rsp_o.stall = 1'b0;
  assign wb_rsp_o.dat   = result_q;

  for (genvar i = 0; i < NUM_DIGITS; i++)
  begin : gen_dec
    hex_digit_decoder u_dec (
      .code_i (codes_q[i]),
      .seg_o  (seg_o[i])
    );
  end

  a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_rsp_o.ack |=> !wb_rsp_o.ack);

  // Every accepted request gets its ack in the next cycle, and no other.
  a_ack_after_accept: assert property (@(posedge clk_i) disable iff (rst_i)
    accept |=> wb_rsp_o.ack);

  a_ack_has_cause: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_rsp_o.ack |-> $past(accept));

endmodule

/* hdl/switch_debouncer.sv */
`timescale 1ns/10ps

module switch_debouncer (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [seg_pkg::SW_WIDTH-1:0] sw_i,
  output logic [seg_pkg::SW_WIDTH-1:0] sw_o
);

  import seg_pkg::*;

  logic [SW_WIDTH-1:0] meta_q;
  logic [SW_WIDTH-1:0] sync_q;
  logic [SW_WIDTH-1:0] sw_q;
  logic [SW_WIDTH-1:0][DEBOUNCE_CNT_W-1:0] cnt_q;

  // Two-flop synchronizer.
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      meta_q <= '0;
      sync_q <= '0;
    end
    else
    begin
      meta_q <= sw_i;
      sync_q <= meta_q;
    end
  end

  // Count while the input disagrees with the output.
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      sw_q  <= '0;
      cnt_q <= '0;
    end
    else
    begin
      for (int i = 0; i < SW_WIDTH; i++)
      begin
        if (sync_q[i] == sw_q[i])
          cnt_q[i] <= '0;
        else if (cnt_q[i] == DEBOUNCE_CNT_W'(DEBOUNCE_CYCLES))
        begin
          sw_q[i]  <= sync_q[i];
          cnt_q[i] <= '0;
        end
        else
          cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  assign sw_o = sw_q;

  for (genvar i = 0; i < SW_WIDTH; i++)
  begin : gen_chk
    a_flip_at_limit: assert property (@(posedge clk_i) disable iff (rst_i)
      $changed(sw_q[i]) |-> $past(cnt_q[i]) == DEBOUNCE_CNT_W'(DEBOUNCE_CYCLES));
  end

endmodule

/* hdl/hex_digit_decoder.sv */
`timescale 1ns/10ps

module hex_digit_decoder (
  input  seg_pkg::digit_code_t         code_i,
  output logic [seg_pkg::SEG_WIDTH-1:0] seg_o
);

  import seg_pkg::*;

  // Patterns in g f e d c b a order.
  always_comb
  begin
    case (code_i)
      5'h00: seg_o = 7'h3f;
      5'h01: seg_o = 7'h06;
      5'h02: seg_o = 7'h5b;
      5'h03: seg_o = 7'h4f;
      5'h04: seg_o = 7'h66;
      5'h05: seg_o = 7'h6d;
      5'h06: seg_o = 7'h7d;
      5'h07: seg_o = 7'h07;
      5'h08: seg_o = 7'h7f;
      5'h09: seg_o = 7'h6f;
      5'h0a: seg_o = 7'h77;
      5'h0b: seg_o = 7'h7c;
      5'h0c: seg_o = 7'h39;
      5'h0d: seg_o = 7'h5e;
      5'h0e: seg_o = 7'h79;
      5'h0f: seg_o = 7'h71;
      5'h10: seg_o = {SEG_WIDTH{1'b0}};
      // Minus sign, segment g only.
      5'h11: seg_o = 7'h40;
      default: seg_o = {SEG_WIDTH{1'b0}};
    endcase
  end

endmodule

/* hdl/seg_pkg.sv */
package seg_pkg;

  // Display geometry.
  localparam int NUM_DIGITS = 8;
  localparam int SEG_WIDTH  = 7;
  localparam int CODE_WIDTH = 5;

  // Slide switch input and its filter length.
  localparam int SW_WIDTH        = 10;
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES + 1);

  // Bus widths.
  localparam int ADR_WIDTH = 32;
  localparam int DAT_WIDTH = 32;

  // Register map.
  // Bit 5 picks the switch register, bits 4..2 the digit index.
  localparam int SW_REG_BIT      = 5;
  localparam int DIGIT_IDX_LSB   = 2;
  localparam int DIGIT_IDX_WIDTH = $clog2(NUM_DIGITS);

  // Request from the bus master.
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [ADR_WIDTH-1:0] adr;
    logic [DAT_WIDTH-1:0] dat;
  } wb_req_t;

  // Response from the slave.
  typedef struct packed {
    logic                 ack;
    logic                 stall;
    logic [DAT_WIDTH-1:0] dat;
  } wb_rsp_t;

  // Segment bits are g f e d c b a, active high.
  typedef logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] seg_digits_t;

  typedef logic [CODE_WIDTH-1:0] digit_code_t;

endpackage
